//--- icache_refill.f
+incdir+include
rtl/icache_refill_pkg.sv
rtl/line_refill_adapter.sv
rtl/burst_read_arbiter.sv
rtl/icache_refill_top.sv
verification/burst_mem_model.sv
verification/tb_icache_refill.sv

//--- include/icache_refill_defs.svh
`ifndef ICACHE_REFILL_DEFS_SVH
`define ICACHE_REFILL_DEFS_SVH

// Byte address width on the cache and bus side
`define ICR_ADDR_W 32

// One beat on the burst-read bus
`define ICR_BEAT_W 64

// One instruction cache line
`define ICR_LINE_W 256

// Beats needed to fill one line
`define ICR_BEATS 4

// Transaction ID width, one ID per fetch port
`define ICR_ID_W 1

`endif

//--- rtl/burst_read_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module burst_read_arbiter import icache_refill_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,

  // Adapter side, index 0 is the instruction-fetch port
  input  logic    [1:0] req_i,
  output logic    [1:0] gnt_o,
  input  addr_t   [1:0] addr_i,
  input  blen_t   [1:0] blen_i,
  input  txn_id_t [1:0] id_i,
  output logic    [1:0] rvalid_o,
  output beat_t         rdata_o,
  output logic          rlast_o,

  // External burst-read bus
  output logic          mem_req_o,
  input  logic          mem_gnt_i,
  output addr_t         mem_addr_o,
  output blen_t         mem_blen_o,
  output txn_id_t       mem_id_o,
  input  logic          mem_rvalid_i,
  input  beat_t         mem_rdata_i,
  input  logic          mem_rlast_i,
  input  txn_id_t       mem_rid_i
);

  arb_state_e state_q;
  logic       sel_q;
  logic       prio_q;
  logic       pick;
  logic       launch;

  // Port at prio_q wins when both are pending
  assign pick   = req_i[prio_q] ? prio_q : ~prio_q;
  assign launch = (state_q == ARB_IDLE) && (|req_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ARB_IDLE;
      sel_q   <= 1'b0;
      prio_q  <= 1'b0;
    end else begin
      if (launch) begin
        state_q <= ARB_ISSUE;
        sel_q   <= pick;
      end else if (state_q == ARB_ISSUE && mem_gnt_i) begin
        state_q <= ARB_IDLE;
        // Other port goes first next time
        prio_q  <= ~sel_q;
      end
    end
  end

  // Request fields are captured once and held until the bus grant
  always_ff @(posedge clk_i) begin
    if (launch) begin
      mem_addr_o <= addr_i[pick];
      mem_blen_o <= blen_i[pick];
      mem_id_o   <= id_i[pick];
    end
  end

  assign mem_req_o = (state_q == ARB_ISSUE);

  always_comb begin
    gnt_o = '0;
    if (state_q == ARB_ISSUE && mem_gnt_i) begin
      gnt_o[sel_q] = 1'b1;
    end
  end

  // Return beats, one register stage, valid steered by ID
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        rvalid_o[i] <= mem_rvalid_i && (mem_rid_i == id_i[i]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_o <= mem_rdata_i;
    rlast_o <= mem_rlast_i;
  end

endmodule

`default_nettype wire

//--- rtl/icache_refill_pkg.sv
`default_nettype none

`include "icache_refill_defs.svh"

package icache_refill_pkg;

  typedef logic [`ICR_ADDR_W-1:0] addr_t;
  typedef logic [`ICR_BEAT_W-1:0] beat_t;

  // Word 0 sits in the low bits and holds the lowest address
  typedef logic [`ICR_LINE_W-1:0] line_t;

  // Burst length minus one
  typedef logic [$clog2(`ICR_BEATS)-1:0] blen_t;
  typedef logic [`ICR_ID_W-1:0]          txn_id_t;

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_REQ,
    RF_COLLECT
  } refill_state_e;

  typedef enum logic {
    ARB_IDLE,
    ARB_ISSUE
  } arb_state_e;

endpackage

`default_nettype wire

//--- rtl/icache_refill_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_refill_top import icache_refill_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,

  // Instruction-fetch port
  input  logic    if_miss_req_i,
  input  addr_t   if_miss_addr_i,
  input  logic    if_miss_nc_i,
  output logic    if_busy_o,
  output logic    if_refill_vld_o,
  output line_t   if_refill_line_o,

  // Data-side fetch port
  input  logic    df_miss_req_i,
  input  addr_t   df_miss_addr_i,
  input  logic    df_miss_nc_i,
  output logic    df_busy_o,
  output logic    df_refill_vld_o,
  output line_t   df_refill_line_o,

  // Shared burst-read bus
  output logic    mem_req_o,
  input  logic    mem_gnt_i,
  output addr_t   mem_addr_o,
  output blen_t   mem_blen_o,
  output txn_id_t mem_id_o,
  input  logic    mem_rvalid_i,
  input  beat_t   mem_rdata_i,
  input  logic    mem_rlast_i,
  input  txn_id_t mem_rid_i
);

  logic    [1:0] rd_req;
  logic    [1:0] rd_gnt;
  addr_t   [1:0] rd_addr;
  blen_t   [1:0] rd_blen;
  txn_id_t [1:0] rd_id;
  logic    [1:0] rd_valid;
  beat_t         rd_data;
  logic          rd_last;

  line_refill_adapter #(
    .ReqId         ( txn_id_t'(0)     )
  ) u_ifetch (
    .clk_i         ( clk_i            ),
    .rst_ni        ( rst_ni           ),
    .miss_req_i    ( if_miss_req_i    ),
    .miss_addr_i   ( if_miss_addr_i   ),
    .miss_nc_i     ( if_miss_nc_i     ),
    .busy_o        ( if_busy_o        ),
    .refill_vld_o  ( if_refill_vld_o  ),
    .refill_line_o ( if_refill_line_o ),
    .rd_req_o      ( rd_req[0]        ),
    .rd_gnt_i      ( rd_gnt[0]        ),
    .rd_addr_o     ( rd_addr[0]       ),
    .rd_blen_o     ( rd_blen[0]       ),
    .rd_id_o       ( rd_id[0]         ),
    .rd_valid_i    ( rd_valid[0]      ),
    .rd_data_i     ( rd_data          ),
    .rd_last_i     ( rd_last          )
  );

  line_refill_adapter #(
    .ReqId         ( txn_id_t'(1)     )
  ) u_dfetch (
    .clk_i         ( clk_i            ),
    .rst_ni        ( rst_ni           ),
    .miss_req_i    ( df_miss_req_i    ),
    .miss_addr_i   ( df_miss_addr_i   ),
    .miss_nc_i     ( df_miss_nc_i     ),
    .busy_o        ( df_busy_o        ),
    .refill_vld_o  ( df_refill_vld_o  ),
    .refill_line_o ( df_refill_line_o ),
    .rd_req_o      ( rd_req[1]        ),
    .rd_gnt_i      ( rd_gnt[1]        ),
    .rd_addr_o     ( rd_addr[1]       ),
    .rd_blen_o     ( rd_blen[1]       ),
    .rd_id_o       ( rd_id[1]         ),
    .rd_valid_i    ( rd_valid[1]      ),
    .rd_data_i     ( rd_data          ),
    .rd_last_i     ( rd_last          )
  );

  burst_read_arbiter u_arb (
    .clk_i         ( clk_i            ),
    .rst_ni        ( rst_ni           ),
    .req_i         ( rd_req           ),
    .gnt_o         ( rd_gnt           ),
    .addr_i        ( rd_addr          ),
    .blen_i        ( rd_blen          ),
    .id_i          ( rd_id            ),
    .rvalid_o      ( rd_valid         ),
    .rdata_o       ( rd_data          ),
    .rlast_o       ( rd_last          ),
    .mem_req_o     ( mem_req_o        ),
    .mem_gnt_i     ( mem_gnt_i        ),
    .mem_addr_o    ( mem_addr_o       ),
    .mem_blen_o    ( mem_blen_o       ),
    .mem_id_o      ( mem_id_o         ),
    .mem_rvalid_i  ( mem_rvalid_i     ),
    .mem_rdata_i   ( mem_rdata_i      ),
    .mem_rlast_i   ( mem_rlast_i      ),
    .mem_rid_i     ( mem_rid_i        )
  );

endmodule

`default_nettype wire

//--- rtl/line_refill_adapter.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_refill_defs.svh"

module line_refill_adapter import icache_refill_pkg::*; #(
  parameter txn_id_t ReqId = '0
) (
  input  logic    clk_i,
  input  logic    rst_ni,

  // Cache side
  input  logic    miss_req_i,
  input  addr_t   miss_addr_i,
  input  logic    miss_nc_i,
  output logic    busy_o,
  output logic    refill_vld_o,
  output line_t   refill_line_o,

  // Towards the arbiter
  output logic    rd_req_o,
  input  logic    rd_gnt_i,
  output addr_t   rd_addr_o,
  output blen_t   rd_blen_o,
  output txn_id_t rd_id_o,
  input  logic    rd_valid_i,
  input  beat_t   rd_data_i,
  input  logic    rd_last_i
);

  localparam int unsigned LineBytes = `ICR_LINE_W / 8;
  localparam int unsigned BeatBytes = `ICR_BEAT_W / 8;
  localparam blen_t       LineBlen  = blen_t'(`ICR_BEATS - 1);

  refill_state_e state_q, state_d;
  addr_t         addr_q;
  logic          nc_q;
  line_t         line_q, line_d;

  // Line-aligned for cached misses, beat-aligned for uncached words
  addr_t         miss_addr_aligned;

  assign miss_addr_aligned = miss_nc_i ? (miss_addr_i & ~addr_t'(BeatBytes - 1))
                                       : (miss_addr_i & ~addr_t'(LineBytes - 1));

  always_comb begin
    state_d      = state_q;
    line_d       = line_q;
    refill_vld_o = 1'b0;

    case (state_q)
      RF_IDLE: begin
        if (miss_req_i) begin
          state_d = RF_REQ;
          line_d  = '0;
        end
      end

      // Request stays up until the arbiter passes on the bus grant
      RF_REQ: begin
        if (rd_gnt_i) begin
          state_d = RF_COLLECT;
        end
      end

      RF_COLLECT: begin
        if (rd_valid_i) begin
          if (nc_q) begin
            // Single word lands at word 0, upper words stay cleared
            line_d = line_t'(rd_data_i);
          end else begin
            line_d = {rd_data_i, line_q[`ICR_LINE_W-1:`ICR_BEAT_W]};
          end
          if (rd_last_i) begin
            refill_vld_o = 1'b1;
            state_d      = RF_IDLE;
          end
        end
      end

      default: state_d = RF_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    line_q <= line_d;
    if (state_q == RF_IDLE && miss_req_i) begin
      addr_q <= miss_addr_aligned;
      nc_q   <= miss_nc_i;
    end
  end

  // Completed line is visible in the same cycle as the last beat
  assign refill_line_o = line_d;
  assign busy_o        = (state_q != RF_IDLE);

  assign rd_req_o  = (state_q == RF_REQ);
  assign rd_addr_o = addr_q;
  assign rd_blen_o = nc_q ? '0 : LineBlen;
  assign rd_id_o   = ReqId;

endmodule

`default_nettype wire

//--- verification/burst_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module burst_mem_model import icache_refill_pkg::*; #(
  parameter int Seed = 32'h5b10_909d
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fair_chk_i,
  input  logic        mem_req_i,
  output logic        mem_gnt_o,
  input  addr_t       mem_addr_i,
  input  blen_t       mem_blen_i,
  input  txn_id_t     mem_id_i,
  output logic        mem_rvalid_o,
  output beat_t       mem_rdata_o,
  output logic        mem_rlast_o,
  output txn_id_t     mem_rid_o,
  output logic [31:0] repeat_cnt_o
);

  integer  gnt_seed;
  integer  beat_seed;
  addr_t   addr_q[$];
  blen_t   blen_q[$];
  txn_id_t id_q[$];
  txn_id_t prev_id;
  logic    prev_vld;

  // Grant 0 to 5 cycles after the request shows up, then queue the burst
  initial begin
    int      delay;
    addr_t   a;
    blen_t   b;
    txn_id_t id;
    gnt_seed     = Seed;
    mem_gnt_o    = 1'b0;
    repeat_cnt_o = '0;
    prev_vld     = 1'b0;
    prev_id      = '0;
    forever begin
      @(posedge clk_i);
      #2;
      if (rst_ni && mem_req_i) begin
        delay = $unsigned($random(gnt_seed)) % 6;
        repeat (delay) begin
          @(posedge clk_i);
          #2;
        end
        a  = mem_addr_i;
        b  = mem_blen_i;
        id = mem_id_i;
        // Same ID twice in a row while both ports keep requesting
        if (fair_chk_i && prev_vld && id == prev_id) begin
          repeat_cnt_o = repeat_cnt_o + 1;
        end
        prev_id   = id;
        prev_vld  = fair_chk_i;
        mem_gnt_o = 1'b1;
        @(posedge clk_i);
        addr_q.push_back(a);
        blen_q.push_back(b);
        id_q.push_back(id);
        #2;
        mem_gnt_o = 1'b0;
      end
    end
  end

  // Beats in address order, 0 to 3 idle cycles before each one
  initial begin
    addr_t   base;
    addr_t   a;
    blen_t   blen;
    txn_id_t id;
    int      gap;
    beat_seed    = Seed + 1;
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
    mem_rlast_o  = 1'b0;
    mem_rid_o    = '0;
    forever begin
      if (addr_q.size() == 0) begin
        @(posedge clk_i);
        #2;
      end else begin
        base = addr_q.pop_front();
        blen = blen_q.pop_front();
        id   = id_q.pop_front();
        for (int k = 0; k <= int'(blen); k++) begin
          gap = $unsigned($random(beat_seed)) % 4;
          repeat (gap) begin
            @(posedge clk_i);
            #2;
          end
          a            = base + addr_t'(8 * k);
          mem_rvalid_o = 1'b1;
          mem_rdata_o  = {a, a ^ 32'hc0de_f00d};
          mem_rlast_o  = (k == int'(blen));
          mem_rid_o    = id;
          @(posedge clk_i);
          #2;
          mem_rvalid_o = 1'b0;
          mem_rlast_o  = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_icache_refill.sv
`timescale 1ns/1ns
`default_nettype none

`include "icache_refill_defs.svh"

module tb_icache_refill import icache_refill_pkg::*; ();

  localparam int ClkPeriod = 20;
  localparam int NumReq    = 108;
  localparam int Seed      = 32'h5b10_909d;

  logic        clk;
  logic        rst_n;
  logic        if_miss_req, if_miss_nc, if_busy, if_refill_vld;
  logic        df_miss_req, df_miss_nc, df_busy, df_refill_vld;
  addr_t       if_miss_addr, df_miss_addr;
  line_t       if_refill_line, df_refill_line;
  logic        mem_req, mem_gnt, mem_rvalid, mem_rlast;
  addr_t       mem_addr;
  blen_t       mem_blen;
  txn_id_t     mem_id, mem_rid;
  beat_t       mem_rdata;
  logic        fair_chk;
  logic [31:0] repeat_cnt;

  integer      seed;
  int          errors, checks, tests;
  addr_t       cur_addr[2];
  logic        cur_nc[2];
  int          issued[2];
  int          returned[2];
  addr_t       rnd_addr[2][40];
  logic        rnd_nc[2][40];

  icache_refill_top dut0 (
    .clk_i            ( clk            ),
    .rst_ni           ( rst_n          ),
    .if_miss_req_i    ( if_miss_req    ),
    .if_miss_addr_i   ( if_miss_addr   ),
    .if_miss_nc_i     ( if_miss_nc     ),
    .if_busy_o        ( if_busy        ),
    .if_refill_vld_o  ( if_refill_vld  ),
    .if_refill_line_o ( if_refill_line ),
    .df_miss_req_i    ( df_miss_req    ),
    .df_miss_addr_i   ( df_miss_addr   ),
    .df_miss_nc_i     ( df_miss_nc     ),
    .df_busy_o        ( df_busy        ),
    .df_refill_vld_o  ( df_refill_vld  ),
    .df_refill_line_o ( df_refill_line ),
    .mem_req_o        ( mem_req        ),
    .mem_gnt_i        ( mem_gnt        ),
    .mem_addr_o       ( mem_addr       ),
    .mem_blen_o       ( mem_blen       ),
    .mem_id_o         ( mem_id         ),
    .mem_rvalid_i     ( mem_rvalid     ),
    .mem_rdata_i      ( mem_rdata      ),
    .mem_rlast_i      ( mem_rlast      ),
    .mem_rid_i        ( mem_rid        )
  );

  burst_mem_model #(.Seed(Seed)) mem0 (
    .clk_i(clk), .rst_ni(rst_n), .fair_chk_i(fair_chk), .mem_req_i(mem_req),
    .mem_gnt_o(mem_gnt), .mem_addr_i(mem_addr), .mem_blen_i(mem_blen), .mem_id_i(mem_id),
    .mem_rvalid_o(mem_rvalid), .mem_rdata_o(mem_rdata), .mem_rlast_o(mem_rlast),
    .mem_rid_o(mem_rid), .repeat_cnt_o(repeat_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic addr_t aligned_addr(addr_t a, logic nc);
    return nc ? {a[31:3], 3'b000} : {a[31:5], 5'b00000};
  endfunction

  function automatic line_t expected_line(addr_t a, logic nc);
    line_t l;
    addr_t base;
    addr_t wa;
    l    = '0;
    base = aligned_addr(a, nc);
    // Word k of the line comes from byte address base + 8k
    for (int k = 0; k < `ICR_BEATS; k++) begin
      wa = base + addr_t'(8 * k);
      if (!nc || k == 0) begin
        l[k*`ICR_BEAT_W +: `ICR_BEAT_W] = {wa, wa ^ 32'hc0de_f00d};
      end
    end
    return l;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_refill(input int p, input line_t line);
    line_t exp;
    exp = expected_line(cur_addr[p], cur_nc[p]);
    checks += 2;
    assert (issued[p] == returned[p] + 1) else begin
      $display("Port %0d returned a line with no miss outstanding", p);
      errors++;
    end
    assert (line === exp) else begin
      $display("ERR %s got %h exp %h", p == 0 ? "if_refill_line_o" : "df_refill_line_o",
               line, exp);
      errors++;
    end
    returned[p]++;
  endtask

  // Compare each refill and each bus grant against the port's current miss
  always @(negedge clk) begin
    if (rst_n) begin
      if (if_refill_vld) check_refill(0, if_refill_line);
      if (df_refill_vld) check_refill(1, df_refill_line);
      if (mem_req && mem_gnt) begin
        check_val("mem_addr_o", mem_addr, aligned_addr(cur_addr[mem_id], cur_nc[mem_id]));
        check_val("mem_blen_o", 32'(mem_blen), cur_nc[mem_id] ? 32'd0 : 32'(`ICR_BEATS - 1));
      end
    end
  end

  task automatic issue_miss(input int p, input addr_t a, input logic nc);
    while (p == 0 ? if_busy : df_busy) begin
      @(posedge clk);
      #2;
    end
    cur_addr[p] = a;
    cur_nc[p]   = nc;
    issued[p]++;
    if (p == 0) begin
      {if_miss_req, if_miss_addr, if_miss_nc} = {1'b1, a, nc};
    end else begin
      {df_miss_req, df_miss_addr, df_miss_nc} = {1'b1, a, nc};
    end
    @(posedge clk);
    #2;
    if (p == 0) if_miss_req = 1'b0;
    else df_miss_req = 1'b0;
  endtask

  task automatic wait_idle();
    @(posedge clk);
    #2;
    while (if_busy || df_busy) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    $display("%-24s %s", name, errors == err0 ? "ok" : "mismatch");
  endtask

  initial begin
    int          err0;
    logic [31:0] r;
    {if_miss_req, if_miss_addr, if_miss_nc} = '0;
    {df_miss_req, df_miss_addr, df_miss_nc} = '0;
    {errors, checks, tests} = '0;
    issued   = '{0, 0};
    returned = '{0, 0};
    fair_chk = 1'b0;
    seed     = Seed;
    rst_n    = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    err0 = errors;
    repeat (5) begin
      @(negedge clk);
      check_val("if_busy_o", if_busy, 0);
      check_val("df_busy_o", df_busy, 0);
      check_val("refill_vld_o", {if_refill_vld, df_refill_vld}, 0);
      check_val("mem_req_o", mem_req, 0);
    end
    @(posedge clk);
    #2;
    finish_test("reset state", err0);

    err0 = errors;
    issue_miss(0, 32'h8000_0044, 1'b0);
    wait_idle();
    check_val("if_refill_vld_o count", returned[0], issued[0]);
    finish_test("ifetch cached line", err0);

    err0 = errors;
    issue_miss(1, 32'h0000_1234, 1'b1);
    wait_idle();
    issue_miss(1, 32'h0000_2238, 1'b0);
    wait_idle();
    finish_test("dfetch uncached word", err0);

    // Same-cycle misses, the lone ifetch miss between rounds hands the next tie
    // to the other port
    err0 = errors;
    fork
      issue_miss(0, 32'h0001_0020, 1'b0);
      issue_miss(1, 32'h0002_0040, 1'b0);
    join
    wait_idle();
    issue_miss(0, 32'h0005_0060, 1'b0);
    wait_idle();
    fork
      issue_miss(0, 32'h0003_00a0, 1'b0);
      issue_miss(1, 32'h0004_00c8, 1'b1);
    join
    wait_idle();
    finish_test("concurrent misses", err0);

    err0 = errors;
    for (int i = 0; i < 80; i++) begin
      rnd_addr[i / 40][i % 40] = $random(seed);
      r = $random(seed);
      rnd_nc[i / 40][i % 40] = r[0];
    end
    fork
      for (int i = 0; i < 40; i++) issue_miss(0, rnd_addr[0][i], rnd_nc[0][i]);
      for (int i = 0; i < 40; i++) issue_miss(1, rnd_addr[1][i], rnd_nc[1][i]);
    join
    wait_idle();
    check_val("if_refill_vld_o count", returned[0], issued[0]);
    check_val("df_refill_vld_o count", returned[1], issued[1]);
    finish_test("random stream", err0);

    err0 = errors;
    fair_chk = 1'b1;
    fork
      for (int i = 0; i < 10; i++) issue_miss(0, 32'h0010_0000 + 32'(i * 32), 1'b0);
      for (int i = 0; i < 10; i++) issue_miss(1, 32'h0020_0000 + 32'(i * 32), 1'b0);
    join
    wait_idle();
    fair_chk = 1'b0;
    check_val("repeated mem_id_o grants", repeat_cnt, 0);
    finish_test("fairness", err0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Each request gets up to 200 cycles
  initial begin
    #(ClkPeriod * (NumReq * 200 + 20));
    $display("Timeout, the refills did not finish within %0d cycles", NumReq * 200 + 20);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
